//--- src/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

   localparam int XLEN   = 64;
   localparam int REG_AW = 5;

   // Major opcodes of the RV64I encodings handled by the decoder
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;

   // Immediate forms share the register-form operations
   typedef enum logic [4:0] {
      ALU_NONE,
      ALU_LUI,
      ALU_AUIPC,
      ALU_JAL,
      ALU_JALR,
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLL,
      ALU_SRL,
      ALU_BEQ,
      ALU_BNE,
      ALU_BLT,
      ALU_BGE,
      ALU_BLTU,
      ALU_BGEU
   } alu_op_e;

   typedef struct packed {
      alu_op_e           op;
      logic [REG_AW-1:0] rd;
      logic [REG_AW-1:0] rs1;
      logic [REG_AW-1:0] rs2;
      logic [XLEN-1:0]   imm;
      logic              use_imm;
      logic              wr_rd;
      logic [XLEN-1:0]   pc;
   } dec_s;

   typedef struct packed {
      logic [REG_AW-1:0] rd;
      logic [XLEN-1:0]   data;
   } wb_s;

endpackage

`default_nettype wire

//--- src/rv_decode.sv
`default_nettype none
`timescale 1ns/1ps

module rv_decode (
   input  logic [31:0]                  i_instr,
   input  logic [rv_exec_pkg::XLEN-1:0] i_pc,
   output rv_exec_pkg::dec_s            o_dec
);

   import rv_exec_pkg::*;

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_ALT  = 7'b0100000;

   logic [6:0]      opcode;
   logic [2:0]      funct3;
   logic [6:0]      funct7;
   logic [XLEN-1:0] imm_i;
   logic [XLEN-1:0] imm_u;
   logic [XLEN-1:0] imm_b;
   logic [XLEN-1:0] imm_j;

   assign opcode = i_instr[6:0];
   assign funct3 = i_instr[14:12];
   assign funct7 = i_instr[31:25];

   // Sign-extended immediates for each format
   assign imm_i = {{52{i_instr[31]}}, i_instr[31:20]};
   assign imm_u = {{32{i_instr[31]}}, i_instr[31:12], 12'b0};
   assign imm_b = {{51{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                   i_instr[11:8], 1'b0};
   assign imm_j = {{43{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                   i_instr[30:21], 1'b0};

   always_comb begin
      o_dec     = '0;
      o_dec.op  = ALU_NONE;
      o_dec.rd  = i_instr[11:7];
      o_dec.rs1 = i_instr[19:15];
      o_dec.rs2 = i_instr[24:20];
      o_dec.pc  = i_pc;

      case (opcode)
         OPC_LUI: begin
            o_dec.op  = ALU_LUI;
            o_dec.imm = imm_u;
         end
         OPC_AUIPC: begin
            o_dec.op  = ALU_AUIPC;
            o_dec.imm = imm_u;
         end
         OPC_JAL: begin
            o_dec.op  = ALU_JAL;
            o_dec.imm = imm_j;
         end
         OPC_JALR: begin
            if (funct3 == 3'b000) o_dec.op = ALU_JALR;
            o_dec.imm = imm_i;
         end
         OPC_BRANCH: begin
            o_dec.imm = imm_b;
            case (funct3)
               3'b000:  o_dec.op = ALU_BEQ;
               3'b001:  o_dec.op = ALU_BNE;
               3'b100:  o_dec.op = ALU_BLT;
               3'b101:  o_dec.op = ALU_BGE;
               3'b110:  o_dec.op = ALU_BLTU;
               3'b111:  o_dec.op = ALU_BGEU;
               default: o_dec.op = ALU_NONE;
            endcase
         end
         OPC_OP_IMM: begin
            o_dec.imm     = imm_i;
            o_dec.use_imm = 1'b1;
            case (funct3)
               3'b000:  o_dec.op = ALU_ADD;
               3'b111:  o_dec.op = ALU_AND;
               3'b110:  o_dec.op = ALU_OR;
               3'b100:  o_dec.op = ALU_XOR;
               3'b001:  o_dec.op = (i_instr[31:26] == 6'b0) ? ALU_SLL : ALU_NONE;
               3'b101:  o_dec.op = (i_instr[31:26] == 6'b0) ? ALU_SRL : ALU_NONE;
               default: o_dec.op = ALU_NONE;
            endcase
         end
         OPC_OP: begin
            if (funct7 == F7_BASE) begin
               case (funct3)
                  3'b000:  o_dec.op = ALU_ADD;
                  3'b111:  o_dec.op = ALU_AND;
                  3'b110:  o_dec.op = ALU_OR;
                  3'b100:  o_dec.op = ALU_XOR;
                  3'b001:  o_dec.op = ALU_SLL;
                  3'b101:  o_dec.op = ALU_SRL;
                  default: o_dec.op = ALU_NONE;
               endcase
            end else if (funct7 == F7_ALT && funct3 == 3'b000) begin
               o_dec.op = ALU_SUB;
            end
         end
         default: o_dec.op = ALU_NONE;
      endcase

      // Branches and unknown encodings leave rd untouched
      o_dec.wr_rd = !(o_dec.op inside {ALU_NONE, ALU_BEQ, ALU_BNE, ALU_BLT,
                                       ALU_BGE, ALU_BLTU, ALU_BGEU});
   end

endmodule

`default_nettype wire

//--- src/rv_regfile.sv
`default_nettype none
`timescale 1ns/1ps

module rv_regfile (
   input  logic                           i_clk,
   input  logic                           i_rst_n,
   input  logic [rv_exec_pkg::REG_AW-1:0] i_rs1,
   input  logic [rv_exec_pkg::REG_AW-1:0] i_rs2,
   output logic [rv_exec_pkg::XLEN-1:0]   o_rs1_data,
   output logic [rv_exec_pkg::XLEN-1:0]   o_rs2_data,
   input  logic                           i_we,
   input  rv_exec_pkg::wb_s               i_wr
);

   import rv_exec_pkg::*;

   localparam int NREGS = 2 ** REG_AW;

   logic [XLEN-1:0] regs [NREGS];

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we && (i_wr.rd != '0)) begin
         regs[i_wr.rd] <= i_wr.data;
      end
   end

   // x0 reads as zero whatever the array holds
   assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
   assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

   a_wr_rd_known : assert property (
      @(posedge i_clk) disable iff (!i_rst_n)
      i_we |-> !$isunknown(i_wr.rd)
   ) else $error("register write with unknown rd");

endmodule

`default_nettype wire

//--- src/rv_alu.sv
`default_nettype none
`timescale 1ns/1ps

module rv_alu (
   input  rv_exec_pkg::alu_op_e         i_op,
   input  logic [rv_exec_pkg::XLEN-1:0] i_pc,
   input  logic [rv_exec_pkg::XLEN-1:0] i_operand1,
   input  logic [rv_exec_pkg::XLEN-1:0] i_operand2,
   input  logic [rv_exec_pkg::XLEN-1:0] i_imm,
   output logic [rv_exec_pkg::XLEN-1:0] o_result,
   output logic                         o_flush,
   output logic [rv_exec_pkg::XLEN-3:0] o_pc_tgt
);

   import rv_exec_pkg::*;

   logic [5:0] shamt;
   logic       taken;
   logic       is_jump;

   assign shamt = i_operand2[5:0];

   ////////////////////////////////////////////////////////////////////////////
   // Result select
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      case (i_op)
         ALU_LUI:           o_result = i_imm;
         ALU_AUIPC:         o_result = i_pc + i_imm;
         ALU_JAL, ALU_JALR: o_result = i_pc + XLEN'(4);
         ALU_ADD:           o_result = i_operand1 + i_operand2;
         ALU_SUB:           o_result = i_operand1 - i_operand2;
         ALU_AND:           o_result = i_operand1 & i_operand2;
         ALU_OR:            o_result = i_operand1 | i_operand2;
         ALU_XOR:           o_result = i_operand1 ^ i_operand2;
         ALU_SLL:           o_result = i_operand1 << shamt;
         ALU_SRL:           o_result = i_operand1 >> shamt;
         default:           o_result = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Branch decision and target
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      case (i_op)
         ALU_BEQ:  taken = (i_operand1 == i_operand2);
         ALU_BNE:  taken = (i_operand1 != i_operand2);
         ALU_BLT:  taken = ($signed(i_operand1) < $signed(i_operand2));
         ALU_BGE:  taken = ($signed(i_operand1) >= $signed(i_operand2));
         ALU_BLTU: taken = (i_operand1 < i_operand2);
         ALU_BGEU: taken = (i_operand1 >= i_operand2);
         default:  taken = 1'b0;
      endcase
   end

   assign is_jump = (i_op == ALU_JAL) || (i_op == ALU_JALR);
   assign o_flush = is_jump || taken;

   // Targets are kept as word addresses
   always_comb begin
      if ((i_op == ALU_JAL) || taken) begin
         o_pc_tgt = i_pc[XLEN-1:2] + i_imm[XLEN-1:2];
      end else if (i_op == ALU_JALR) begin
         o_pc_tgt = i_operand1[XLEN-1:2] + i_imm[XLEN-1:2];
      end else begin
         o_pc_tgt = '0;
      end
   end

endmodule

`default_nettype wire

//--- src/rv_exec_stage.sv
`default_nettype none
`timescale 1ns/1ps

module rv_exec_stage (
   input  logic                         i_clk,
   input  logic                         i_rst_n,
   input  logic                         i_valid,
   input  rv_exec_pkg::dec_s            i_dec,
   input  logic [rv_exec_pkg::XLEN-1:0] i_rs1_data,
   input  logic [rv_exec_pkg::XLEN-1:0] i_rs2_data,
   output logic                         o_rf_we,
   output rv_exec_pkg::wb_s             o_rf_wr,
   output logic                         o_wb_valid,
   output rv_exec_pkg::wb_s             o_wb,
   output logic                         o_redirect_valid,
   output logic [rv_exec_pkg::XLEN-1:0] o_redirect_pc
);

   import rv_exec_pkg::*;

   logic            ex_valid;
   dec_s            ex_dec;
   logic [XLEN-1:0] ex_op1;
   logic [XLEN-1:0] ex_op2;
   logic [XLEN-1:0] alu_result;
   logic            alu_flush;
   logic [XLEN-3:0] alu_pc_tgt;
   logic            fwd_ok;
   logic [XLEN-1:0] fwd_rs1;
   logic [XLEN-1:0] fwd_rs2;
   logic            squash;

   ////////////////////////////////////////////////////////////////////////////
   // Forwarding and execute register
   ////////////////////////////////////////////////////////////////////////////

   assign fwd_ok  = ex_valid && ex_dec.wr_rd && (ex_dec.rd != '0);
   assign fwd_rs1 = (fwd_ok && (ex_dec.rd == i_dec.rs1)) ? alu_result : i_rs1_data;
   assign fwd_rs2 = (fwd_ok && (ex_dec.rd == i_dec.rs2)) ? alu_result : i_rs2_data;

   // A redirect kills whatever enters behind it
   assign squash = ex_valid && alu_flush;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ex_valid <= 1'b0;
      end else begin
         ex_valid <= i_valid && !squash;
      end
   end

   always_ff @(posedge i_clk) begin
      ex_dec <= i_dec;
      ex_op1 <= fwd_rs1;
      ex_op2 <= i_dec.use_imm ? i_dec.imm : fwd_rs2;
   end

   rv_alu u_alu (
      .i_op       (ex_dec.op),
      .i_pc       (ex_dec.pc),
      .i_operand1 (ex_op1),
      .i_operand2 (ex_op2),
      .i_imm      (ex_dec.imm),
      .o_result   (alu_result),
      .o_flush    (alu_flush),
      .o_pc_tgt   (alu_pc_tgt)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Writeback and redirect
   ////////////////////////////////////////////////////////////////////////////

   assign o_rf_we      = ex_valid && ex_dec.wr_rd;
   assign o_rf_wr.rd   = ex_dec.rd;
   assign o_rf_wr.data = alu_result;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_wb_valid       <= 1'b0;
         o_redirect_valid <= 1'b0;
      end else begin
         o_wb_valid       <= o_rf_we;
         o_redirect_valid <= squash;
      end
   end

   always_ff @(posedge i_clk) begin
      o_wb          <= o_rf_wr;
      o_redirect_pc <= {alu_pc_tgt, 2'b00};
   end

   a_redirect_pulse : assert property (
      @(posedge i_clk) disable iff (!i_rst_n)
      o_redirect_valid |=> !o_redirect_valid
   ) else $error("redirect held for two cycles");

endmodule

`default_nettype wire

//--- src/rv_exec_top.sv
`default_nettype none
`timescale 1ns/1ps

module rv_exec_top (
   input  logic                         i_clk,
   input  logic                         i_rst_n,
   input  logic                         i_valid,
   input  logic [31:0]                  i_instr,
   input  logic [rv_exec_pkg::XLEN-1:0] i_pc,
   output logic                         o_wb_valid,
   output rv_exec_pkg::wb_s             o_wb,
   output logic                         o_redirect_valid,
   output logic [rv_exec_pkg::XLEN-1:0] o_redirect_pc
);

   import rv_exec_pkg::*;

   dec_s            dec;
   logic [XLEN-1:0] rs1_data;
   logic [XLEN-1:0] rs2_data;
   logic            rf_we;
   wb_s             rf_wr;

   rv_decode u_decode (
      .i_instr (i_instr),
      .i_pc    (i_pc),
      .o_dec   (dec)
   );

   rv_regfile u_regfile (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_rs1      (dec.rs1),
      .i_rs2      (dec.rs2),
      .o_rs1_data (rs1_data),
      .o_rs2_data (rs2_data),
      .i_we       (rf_we),
      .i_wr       (rf_wr)
   );

   rv_exec_stage u_exec (
      .i_clk            (i_clk),
      .i_rst_n          (i_rst_n),
      .i_valid          (i_valid),
      .i_dec            (dec),
      .i_rs1_data       (rs1_data),
      .i_rs2_data       (rs2_data),
      .o_rf_we          (rf_we),
      .o_rf_wr          (rf_wr),
      .o_wb_valid       (o_wb_valid),
      .o_wb             (o_wb),
      .o_redirect_valid (o_redirect_valid),
      .o_redirect_pc    (o_redirect_pc)
   );

endmodule

`default_nettype wire

//--- bench/rv_exec_tb.sv
`default_nettype none
`timescale 1ns/1ps

module rv_exec_tb;

   import rv_exec_pkg::*;

   localparam int MAX_CYCLES = 2000;

   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_AUIPC  = 7'b0010111;
   localparam logic [6:0] OP_JAL    = 7'b1101111;
   localparam logic [6:0] OP_JALR   = 7'b1100111;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_REG    = 7'b0110011;

   // Expected response of one issue slot
   typedef struct packed {
      logic        wbv;
      logic [4:0]  rd;
      logic [63:0] data;
      logic        rv;
      logic [63:0] rpc;
   } exp_s;

   logic        clk;
   logic        i_rst_n;
   logic        i_valid;
   logic [31:0] i_instr;
   logic [63:0] i_pc;
   logic        o_wb_valid;
   wb_s         o_wb;
   logic        o_redirect_valid;
   logic [63:0] o_redirect_pc;

   logic [63:0] model_regs [32];
   exp_s        pending [$];
   logic [63:0] next_pc;
   logic        flush_prev;
   int          seed;
   int          errors;
   int          checks;
   int          cycles = 0;

   rv_exec_top UUT (
      .i_clk            (clk),
      .i_rst_n          (i_rst_n),
      .i_valid          (i_valid),
      .i_instr          (i_instr),
      .i_pc             (i_pc),
      .o_wb_valid       (o_wb_valid),
      .o_wb             (o_wb),
      .o_redirect_valid (o_redirect_valid),
      .o_redirect_pc    (o_redirect_pc)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("sim failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Instruction encoders
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] r_type(input logic [2:0] f3, input logic [6:0] f7,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, OP_REG};
   endfunction

   function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [19:0] imm);
      return {imm, rd, opc};
   endfunction

   function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
   endfunction

   function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [63:0] alu_result(input logic [2:0] f3, input logic alt,
                                              input logic [63:0] a, input logic [63:0] b);
      case (f3)
         3'b000:  return alt ? a - b : a + b;
         3'b111:  return a & b;
         3'b110:  return a | b;
         3'b100:  return a ^ b;
         3'b001:  return a << b[5:0];
         3'b101:  return a >> b[5:0];
         default: return 64'd0;
      endcase
   endfunction

   function automatic logic branch_taken(input logic [2:0] f3, input logic [63:0] a,
                                         input logic [63:0] b);
      case (f3)
         3'b000:  return a == b;
         3'b001:  return a != b;
         3'b100:  return $signed(a) < $signed(b);
         3'b101:  return $signed(a) >= $signed(b);
         3'b110:  return a < b;
         3'b111:  return a >= b;
         default: return 1'b0;
      endcase
   endfunction

   task automatic predict_outcome(input logic [31:0] ins, input logic [63:0] pc,
                                  output exp_s e);
      logic [63:0] a;
      logic [63:0] b;
      logic [63:0] imm_i;
      logic [63:0] target;
      logic [2:0]  f3;
      e      = '0;
      f3     = ins[14:12];
      a      = model_regs[ins[19:15]];
      b      = model_regs[ins[24:20]];
      imm_i  = {{52{ins[31]}}, ins[31:20]};
      target = '0;
      e.rd   = ins[11:7];
      case (ins[6:0])
         OP_LUI: begin
            e.wbv  = 1'b1;
            e.data = {{32{ins[31]}}, ins[31:12], 12'h000};
         end
         OP_AUIPC: begin
            e.wbv  = 1'b1;
            e.data = pc + {{32{ins[31]}}, ins[31:12], 12'h000};
         end
         OP_JAL: begin
            e.wbv  = 1'b1;
            e.rv   = 1'b1;
            e.data = pc + 64'd4;
            target = pc + {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
         end
         OP_JALR: begin
            e.wbv  = (f3 == 3'b000);
            e.rv   = (f3 == 3'b000);
            e.data = pc + 64'd4;
            target = a + imm_i;
         end
         OP_BRANCH: begin
            e.rv   = (f3 != 3'b010) && (f3 != 3'b011) && branch_taken(f3, a, b);
            target = pc + {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
         end
         OP_IMM: begin
            if ((f3 == 3'b001) || (f3 == 3'b101)) e.wbv = (ins[31:26] == 6'b0);
            else e.wbv = (f3 != 3'b010) && (f3 != 3'b011);
            e.data = alu_result(f3, 1'b0, a, imm_i);
         end
         OP_REG: begin
            e.wbv = ((ins[31:25] == 7'h00) && (f3 != 3'b010) && (f3 != 3'b011)) ||
                    ((ins[31:25] == 7'h20) && (f3 == 3'b000));
            e.data = alu_result(f3, ins[30], a, b);
         end
         default: e.wbv = 1'b0;
      endcase
      // Redirect targets are word addresses
      e.rpc = target & ~64'd3;
      if (e.wbv && (e.rd != 5'd0)) model_regs[e.rd] = e.data;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Issue and compare
   ////////////////////////////////////////////////////////////////////////////

   task automatic count_error(input string msg);
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      errors++;
   endtask

   task automatic compare_outputs(input exp_s e);
      checks++;
      assert ((o_wb_valid === e.wbv) && (o_redirect_valid === e.rv))
      else count_error($sformatf("wb_valid=%b redirect_valid=%b, expected %b %b",
                                 o_wb_valid, o_redirect_valid, e.wbv, e.rv));
      if (e.wbv) begin
         assert ((o_wb.rd === e.rd) && (o_wb.data === e.data))
         else count_error($sformatf("write x%0d=%h, expected x%0d=%h",
                                    o_wb.rd, o_wb.data, e.rd, e.data));
      end
      if (e.rv) begin
         assert (o_redirect_pc === e.rpc)
         else count_error($sformatf("redirect to %h, expected %h", o_redirect_pc, e.rpc));
      end
   endtask

   // Outputs of a slot show up two edges after it is driven
   task automatic issue_slot(input logic v, input logic [31:0] ins, input logic [63:0] pc);
      exp_s e;
      exp_s due;
      e = '0;
      if (v && !flush_prev) predict_outcome(ins, pc, e);
      flush_prev = e.rv;
      @(posedge clk);
      i_valid <= v;
      i_instr <= ins;
      i_pc    <= pc;
      pending.push_back(e);
      @(negedge clk);
      due = pending.pop_front();
      compare_outputs(due);
   endtask

   task automatic issue_instr(input logic [31:0] ins);
      issue_slot(1'b1, ins, next_pc);
      next_pc = next_pc + 64'd4;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) issue_slot(1'b0, 32'h0000_0013, 64'd0);
   endtask

   task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
      logic [19:0] upper;
      upper = v[31:12] + {19'b0, v[11]};
      issue_instr(u_type(OP_LUI, rd, upper));
      issue_instr(i_type(OP_IMM, 3'b000, rd, rd, v[11:0]));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_arith();
      logic [31:0] r;
      repeat (8) begin
         load_reg(5'd1, $random(seed));
         load_reg(5'd2, $random(seed));
         issue_instr(r_type(3'b000, 7'h00, 5'd3, 5'd1, 5'd2));
         issue_instr(r_type(3'b000, 7'h20, 5'd4, 5'd1, 5'd2));
         issue_instr(r_type(3'b111, 7'h00, 5'd5, 5'd1, 5'd2));
         issue_instr(r_type(3'b110, 7'h00, 5'd6, 5'd1, 5'd2));
         issue_instr(r_type(3'b100, 7'h00, 5'd7, 5'd1, 5'd2));
         issue_instr(r_type(3'b001, 7'h00, 5'd8, 5'd1, 5'd2));
         issue_instr(r_type(3'b101, 7'h00, 5'd9, 5'd1, 5'd2));
         r = $random(seed);
         issue_instr(i_type(OP_IMM, 3'b000, 5'd10, 5'd1, r[11:0]));
         issue_instr(i_type(OP_IMM, 3'b111, 5'd11, 5'd2, r[23:12]));
         issue_instr(i_type(OP_IMM, 3'b110, 5'd12, 5'd1, r[31:20]));
         issue_instr(i_type(OP_IMM, 3'b100, 5'd13, 5'd2, r[19:8]));
         issue_instr(i_type(OP_IMM, 3'b001, 5'd14, 5'd2, {6'b0, r[5:0]}));
         issue_instr(i_type(OP_IMM, 3'b101, 5'd15, 5'd1, {6'b0, r[11:6]}));
      end
   endtask

   // Each instruction depends on the one just ahead and on the one two slots back
   task automatic check_forwarding();
      logic [31:0] r;
      repeat (16) begin
         r = $random(seed);
         issue_instr(i_type(OP_IMM, 3'b000, 5'd20, 5'd20, r[11:0]));
         issue_instr(r_type(3'b000, 7'h00, 5'd21, 5'd20, 5'd20));
         issue_instr(r_type(3'b000, 7'h20, 5'd22, 5'd21, 5'd20));
         issue_instr(r_type(3'b100, 7'h00, 5'd20, 5'd22, 5'd21));
         issue_instr(i_type(OP_IMM, 3'b001, 5'd21, 5'd20, {6'b0, r[17:12]}));
         issue_instr(r_type(3'b110, 7'h00, 5'd22, 5'd22, 5'd21));
      end
   endtask

   task automatic check_branches();
      logic [31:0] r;
      logic [2:0]  f3;
      repeat (3) begin
         // x1 is negative and x2 positive, so every branch sees both outcomes
         load_reg(5'd1, $random(seed) | 32'h8000_0000);
         load_reg(5'd2, $random(seed) & 32'h7fff_ffff);
         for (int k = 0; k < 6; k++) begin
            f3 = (k < 2) ? k[2:0] : k[2:0] + 3'd2;
            r  = $random(seed);
            issue_instr(b_type(f3, 5'd1, 5'd1, {r[12:2], 2'b00}));
            issue_instr(i_type(OP_IMM, 3'b000, 5'd9, 5'd9, 12'd1));
            issue_instr(b_type(f3, 5'd1, 5'd2, {r[22:12], 2'b00}));
            issue_instr(i_type(OP_IMM, 3'b000, 5'd9, 5'd9, 12'd1));
            issue_instr(b_type(f3, 5'd2, 5'd1, {r[31:21], 2'b00}));
            issue_instr(i_type(OP_IMM, 3'b000, 5'd9, 5'd9, 12'd1));
         end
      end
   endtask

   task automatic check_jumps();
      logic [31:0] r;
      repeat (3) begin
         r = $random(seed);
         issue_instr(u_type(OP_LUI, 5'd10, r[31:12]));
         issue_instr(u_type(OP_AUIPC, 5'd11, r[19:0]));
         issue_instr(j_type(5'd12, {r[20:2], 2'b00}));
         issue_instr(i_type(OP_IMM, 3'b000, 5'd13, 5'd13, 12'd1));
         load_reg(5'd14, $random(seed) & 32'hffff_fffc);
         issue_instr(i_type(OP_JALR, 3'b000, 5'd15, 5'd14, {r[11:2], 2'b00}));
         issue_instr(i_type(OP_IMM, 3'b000, 5'd13, 5'd13, 12'd1));
         issue_instr(r_type(3'b000, 7'h00, 5'd16, 5'd12, 5'd15));
      end
   endtask

   task automatic check_x0_and_unsupported();
      issue_instr(i_type(OP_IMM, 3'b000, 5'd0, 5'd1, 12'h123));
      issue_instr(r_type(3'b000, 7'h00, 5'd17, 5'd0, 5'd0));
      issue_instr(u_type(OP_LUI, 5'd0, 20'habcde));
      idle_cycles(1);
      issue_instr(r_type(3'b110, 7'h00, 5'd18, 5'd0, 5'd1));
      // A load, an all-ones word and a register op with a bad funct7
      issue_instr(32'h0000_3003);
      issue_instr(32'hffff_ffff);
      issue_instr(r_type(3'b111, 7'h20, 5'd19, 5'd1, 5'd2));
      issue_instr(r_type(3'b000, 7'h00, 5'd19, 5'd19, 5'd0));
   endtask

   initial begin
      seed       = 58;
      errors     = 0;
      checks     = 0;
      flush_prev = 1'b0;
      next_pc    = 64'h0000_0000_8000_0000;
      i_rst_n    = 1'b0;
      i_valid    = 1'b0;
      i_instr    = 32'h0000_0013;
      i_pc       = 64'd0;
      for (int i = 0; i < 32; i++) begin
         model_regs[i] = 64'd0;
      end
      // Outputs are still in reset for the first two slots
      pending.push_back('0);
      pending.push_back('0);
      repeat (3) @(posedge clk);
      i_rst_n <= 1'b1;

      idle_cycles(6);
      check_arith();
      check_forwarding();
      check_branches();
      check_jumps();
      check_x0_and_unsupported();
      idle_cycles(2);

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- rv_exec.f
src/rv_exec_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_exec_stage.sv
src/rv_exec_top.sv
bench/rv_exec_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the rv_exec testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module rv_exec_tb \
   -f rv_exec.f \
   -o rv_exec_sim

./obj_dir/rv_exec_sim | tee sim.log

if grep -qx "sim passed" sim.log; then
   echo "PASS"
   exit 0
fi
echo "FAIL"
exit 1
